//--- build.f
+incdir+source
source/cpuPkg.sv
source/pipeCtl.sv
source/pipeRegs.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/hazardUnit.sv
source/cpuTop.sv
verification/cpu_assert.sv
verification/cpuTb.sv

//--- verification/cpuTb.sv
`include "cpu_cfg.svh"

module cpuTb;
	import cpuPkg::*;

	logic clk;
	logic rst;
	logic progWe;
	logic [$clog2(`CPU_IMEM_WORDS)-1:0] progAddr;
	logic [`CPU_XLEN-1:0] progData;
	logic retireValid;
	logic [`CPU_XLEN-1:0] retirePc;
	logic [4:0] retireRd;
	logic retireWe;
	logic [`CPU_XLEN-1:0] retireData;
	logic [4:0] retireExc;

	logic [31:0] prog [$];
	logic [31:0] expPc [$];
	logic [31:0] expRd [$];
	logic [31:0] expWe [$];
	logic [31:0] expData [$];
	logic [31:0] expExc [$];
	logic [31:0] haltWord;
	logic rstSampled = 1'b0;
	int errors = 0;
	int checks = 0;
	int cycleCount = 0;
	int limit = 0;
	int sinceRelease = 0;
	bit running = 0;
	bit firstRetire = 0;

	cpuTop uut (.clk, .rst, .progWe, .progAddr, .progData, .retireValid, .retirePc,
		.retireRd, .retireWe, .retireData, .retireExc);

	always #2 clk = ~clk;

	task automatic emitR(input logic [5:0] fn, input logic [4:0] rd, input logic [4:0] rs,
		input logic [4:0] rt);
		prog.push_back({6'h00, rs, rt, rd, 5'h00, fn});
	endtask

	task automatic emitI(input logic [5:0] op, input logic [4:0] rt, input logic [4:0] rs,
		input logic [15:0] imm);
		prog.push_back({op, rs, rt, imm});
	endtask

	task automatic finishProgram();
		prog.push_back(haltWord); // branch to itself ends the program
		emitR(fnOr, 0, 0, 0);
		emitR(fnOr, 0, 0, 0);
	endtask

	// architectural interpreter, one retirement per executed instruction
	function automatic void refRun();
		logic [31:0] regs [32];
		logic [31:0] mem [256];
		logic [31:0] pc, ins, a, b, imm, res, addr, nextPc;
		logic [5:0] op;
		logic [4:0] rs, rt, rd, exc;
		logic we;
		int steps;
		for (int i = 0; i < 32; i++) regs[i] = '0;
		for (int i = 0; i < 256; i++) mem[i] = '0;
		pc = `CPU_RESET_PC;
		steps = 0;
		while (steps < 2000) begin
			ins = prog[pc >> 2];
			if (ins == haltWord) break;
			op = ins[31:26];
			rs = ins[25:21];
			rt = ins[20:16];
			a = regs[rs];
			b = regs[rt];
			imm = {{16{ins[15]}}, ins[15:0]};
			addr = a + imm;
			rd = (op == 6'h00) ? ins[15:11] : rt;
			we = 1'b1;
			exc = excNone;
			res = '0;
			nextPc = pc + 4;
			case (op)
				opSpecial: begin
					case (ins[5:0])
						fnAdd: begin
							res = a + b;
							if (a[31] == b[31] && res[31] != a[31]) exc = excOverflow;
						end
						fnAddu: res = a + b;
						fnSubu: res = a - b;
						fnAnd: res = a & b;
						fnOr: res = a | b;
						fnXor: res = a ^ b;
						fnSlt: res = {31'b0, $signed(a) < $signed(b)};
						default: exc = excReservedInstr;
					endcase
				end
				opAddiu: res = addr;
				opOri: res = a | {16'h0, ins[15:0]};
				opLui: res = {ins[15:0], 16'h0};
				opLw: res = mem[addr[9:2]];
				opSw: begin
					mem[addr[9:2]] = b;
					we = 1'b0;
				end
				opBeq: begin
					we = 1'b0;
					if (a == b) nextPc = pc + 4 + (imm << 2);
				end
				opBne: begin
					we = 1'b0;
					if (a != b) nextPc = pc + 4 + (imm << 2);
				end
				default: exc = excReservedInstr;
			endcase
			if (rd == 5'd0 || exc != excNone) we = 1'b0;
			if (we) regs[rd] = res;
			expPc.push_back(pc);
			expRd.push_back({27'b0, rd});
			expWe.push_back({31'b0, we});
			expData.push_back(res);
			expExc.push_back({27'b0, exc});
			pc = nextPc;
			steps++;
		end
	endfunction

	task automatic buildDirected();
		prog.delete();
		emitI(opAddiu, 1, 0, 16'd5);
		emitI(opAddiu, 2, 0, 16'hfffd);
		emitI(opAddiu, 17, 0, 16'd9);
		emitR(fnAddu, 3, 1, 2); // each op reads the result just before it
		emitR(fnSubu, 4, 3, 1);
		emitR(fnAnd, 5, 4, 2);
		emitR(fnOr, 6, 5, 3);
		emitR(fnXor, 7, 6, 4);
		emitR(fnSlt, 8, 7, 1);
		emitI(opAddiu, 9, 8, 16'd100);
		emitI(opOri, 10, 9, 16'hf0f0);
		emitI(opLui, 11, 0, 16'h8000);
		emitI(opSw, 10, 0, 16'd8);
		emitI(opLw, 12, 0, 16'd8);
		emitR(fnAddu, 13, 12, 1); // load-use stall
		emitI(opAddiu, 14, 0, 16'd3);
		emitI(opAddiu, 14, 14, 16'hffff);
		emitI(opBne, 0, 14, 16'hfffe); // backward loop, rt is r0
		emitI(opBeq, 0, 14, 16'd1);
		emitI(opAddiu, 15, 0, 16'd77); // skipped by the taken branch
		emitI(opBeq, 0, 1, 16'd1);
		emitI(opBne, 1, 1, 16'd1);
		emitI(opAddiu, 16, 0, 16'd1);
		emitR(fnAdd, 17, 11, 11); // overflows, r17 keeps 9
		emitR(6'h3f, 16, 1, 1); // reserved funct
		prog.push_back(32'hfc00_0000); // reserved opcode
		emitR(fnAddu, 18, 17, 16);
		emitR(fnAddu, 0, 1, 1);
		finishProgram();
	endtask

	task automatic buildRandom();
		logic [4:0] rd, rs, rt;
		logic [15:0] imm;
		int kind;
		prog.delete();
		for (int i = 1; i < 8; i++) emitI(opAddiu, 5'(i), 0, 16'($urandom));
		for (int i = 0; i < 8; i++) emitI(opSw, 5'(i), 0, 16'(i * 4)); // fill the data window
		for (int n = 0; n < 40; n++) begin
			kind = $urandom % 12;
			rd = 5'(1 + $urandom % 7);
			rs = 5'($urandom % 8);
			rt = 5'($urandom % 8);
			imm = 16'($urandom);
			case (kind)
				0: emitR(fnAdd, rd, rs, rt);
				1: emitR(fnAddu, rd, rs, rt);
				2: emitR(fnSubu, rd, rs, rt);
				3: emitR(fnAnd, rd, rs, rt);
				4: emitR(fnOr, rd, rs, rt);
				5: emitR(fnXor, rd, rs, rt);
				6: emitR(fnSlt, rd, rs, rt);
				7: emitI(opAddiu, rd, rs, imm);
				8: emitI(opOri, rd, rs, imm);
				9: emitI(opLui, rd, 0, imm);
				10: emitI(opLw, rd, 0, 16'(4 * ($urandom % 8)));
				default: emitI(opSw, rt, 0, 16'(4 * ($urandom % 8)));
			endcase
		end
		finishProgram();
	endtask

	task automatic runProgram();
		@(negedge clk);
		rst = 1'b0;
		@(posedge clk);
		refRun();
		limit = 4 * (expPc.size() + 10);
		foreach (prog[i]) begin
			@(negedge clk);
			progWe = 1'b1;
			progAddr = i[7:0];
			progData = prog[i];
		end
		@(negedge clk);
		progWe = 1'b0;
		@(negedge clk);
		rst = 1'b1;
		cycleCount = 0;
		firstRetire = 1'b1;
		running = 1'b1;
		while (expPc.size() > 0) begin
			@(negedge clk);
		end
		@(negedge clk);
		running = 1'b0;
	endtask

	task automatic compareField(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	always @(posedge clk) begin
		rstSampled <= rst; // reset as the last clock edge saw it
	end

	// outputs settle after the rising edge, so they are sampled on the falling one
	always @(negedge clk) begin
		if (!rstSampled) begin
			sinceRelease = 0;
			assert (retireValid !== 1'b1) else begin
				errors++;
				$display("A retirement appeared at %0t while reset was held", $time);
			end
		end else begin
			sinceRelease++;
			if (sinceRelease == 1) begin
				assert (retireValid !== 1'b1) else begin
					errors++;
					$display("A retirement appeared at %0t in the first cycle after reset", $time);
				end
			end
			if (retireValid === 1'b1 && expPc.size() > 0) begin
				if (firstRetire) compareField("first retirePc", retirePc, `CPU_RESET_PC);
				firstRetire = 1'b0;
				compareField("retirePc", retirePc, expPc.pop_front());
				compareField("retireRd", {27'b0, retireRd}, expRd.pop_front());
				compareField("retireWe", {31'b0, retireWe}, expWe[0]);
				compareField("retireExc", {27'b0, retireExc}, expExc.pop_front());
				if (expWe.pop_front() == 1) begin
					compareField("retireData", retireData, expData[0]);
				end
				void'(expData.pop_front());
			end
		end
	end

	always @(posedge clk) begin
		if (running) begin
			cycleCount++;
			if (cycleCount > limit) begin
				$display("Timeout, %0d expected retirements never arrived", expPc.size());
				$display("Test FAILED");
				$finish;
			end
		end
	end

	initial begin
		clk = 1'b0;
		rst = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		haltWord = {opBeq, 5'd0, 5'd0, 16'hffff};
		void'($urandom(32'h4ba3));
		buildDirected();
		runProgram();
		repeat (3) begin
			buildRandom();
			runProgram();
		end
		errors += uut.retireChecks.fails;
		$display("%0d errors in %0d checks", errors, checks);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- verification/cpu_assert.sv
`include "cpu_cfg.svh"

module cpuAssert (
	input logic clk,
	input logic rst,
	input logic retireValid,
	input logic [`CPU_XLEN-1:0] retirePc,
	input logic [4:0] retireRd,
	input logic retireWe,
	input logic [4:0] retireExc
);
	import cpuPkg::*;

	int fails = 0;

	weNoExc: assert property (@(posedge clk) disable iff (!rst)
		retireWe |-> retireExc == excNone) else begin
		$error("register write retired with an exception");
		fails++;
	end

	weNotZero: assert property (@(posedge clk) disable iff (!rst)
		retireWe |-> retireRd != 5'd0) else begin
		$error("register write retired to register zero");
		fails++;
	end

	pcAligned: assert property (@(posedge clk) disable iff (!rst)
		retireValid |-> retirePc[1:0] == 2'b00) else begin
		$error("retired pc is not word aligned");
		fails++;
	end

	// the slot is cleared by the reset edge itself
	quietAfterReset: assert property (@(posedge clk)
		!rst |=> !retireValid) else begin
		$error("retirement in the cycle after reset");
		fails++;
	end

endmodule

bind cpuTop cpuAssert retireChecks (.clk, .rst, .retireValid, .retirePc, .retireRd,
	.retireWe, .retireExc);

//--- source/cpuTop.sv
`include "cpu_cfg.svh"

module cpuTop (
	input logic clk,
	input logic rst,
	input logic progWe,
	input logic [$clog2(`CPU_IMEM_WORDS)-1:0] progAddr,
	input logic [`CPU_XLEN-1:0] progData,
	output logic retireValid,
	output logic [`CPU_XLEN-1:0] retirePc,
	output logic [4:0] retireRd,
	output logic retireWe,
	output logic [`CPU_XLEN-1:0] retireData,
	output logic [4:0] retireExc
);
	import cpuPkg::*;

	pipeCtl ctl ();

	ifSlot_t ifNext, ifCur;
	idSlot_t idNext, idCur;
	exSlot_t exNext, exCur;
	wbSlot_t wbNext, wbCur;
	fwdSel_t fwdA, fwdB;
	logic [4:0] rs, rt;
	logic branchTaken;
	logic [`CPU_XLEN-1:0] branchTarget;

	pipeRegs regs (.clk, .rst, .ctl(ctl.regs), .ifNext, .idNext, .exNext, .wbNext,
		.ifCur, .idCur, .exCur, .wbCur);

	fetchStage fetch (.clk, .rst, .progWe, .progAddr, .progData, .ctl(ctl.regs),
		.branchTaken, .branchTarget, .ifNext);

	// forwarding taps the slots leaving execute and memory, and the register file is
	// written as a result leaves memory, so decode sees each result the cycle it is made
	decodeStage decode (.clk, .ifCur, .wbCur(wbNext), .memFwd(exNext), .fwdA, .fwdB,
		.idNext, .rs, .rt);

	executeStage execute (.idCur, .exNext, .branchTaken, .branchTarget);

	memoryStage memory (.clk, .exCur, .wbNext);

	hazardUnit hazard (.ifCur, .idCur, .exCur(exNext), .wbCur(wbNext), .rs, .rt,
		.branchTaken, .ctl(ctl.hazard), .fwdA, .fwdB);

	assign retireValid = wbCur.valid;
	assign retirePc = wbCur.pc;
	assign retireRd = wbCur.rd;
	assign retireWe = wbCur.regWrite; // already low for an excepting instruction
	assign retireData = wbCur.data;
	assign retireExc = wbCur.excCode;

endmodule

//--- source/hazardUnit.sv
module hazardUnit (
	input cpuPkg::ifSlot_t ifCur,
	input cpuPkg::idSlot_t idCur,
	input cpuPkg::exSlot_t exCur,
	input cpuPkg::wbSlot_t wbCur,
	input logic [4:0] rs,
	input logic [4:0] rt,
	input logic branchTaken,
	pipeCtl.hazard ctl,
	output cpuPkg::fwdSel_t fwdA,
	output cpuPkg::fwdSel_t fwdB
);
	import cpuPkg::*;

	logic loadUse;

	// the younger producer is checked last so it takes priority
	function automatic fwdSel_t pick(input logic [4:0] src);
		fwdSel_t sel;
		sel = fwdReg;
		if (src != 5'd0 && wbCur.valid && wbCur.regWrite && wbCur.rd == src) begin
			sel = fwdWb;
		end
		if (src != 5'd0 && exCur.valid && exCur.regWrite && exCur.rd == src) begin
			sel = fwdMem;
		end
		return sel;
	endfunction

	always_comb begin
		fwdA = pick(rs);
		fwdB = pick(rt);
	end

	// load data only exists once the load has left execute
	assign loadUse = ifCur.valid && idCur.valid && idCur.memRead && (idCur.rd != 5'd0)
		&& (idCur.rd == rs || idCur.rd == rt);

	assign ctl.pcWr = !loadUse || branchTaken;
	assign ctl.ifIdWr = !loadUse;
	assign ctl.idExWr = 1'b1;
	assign ctl.exMemWr = 1'b1;
	assign ctl.memWbWr = 1'b1;
	assign ctl.ifIdFlush = branchTaken;
	assign ctl.idExFlush = branchTaken || loadUse;
	assign ctl.exMemFlush = 1'b0;
	assign ctl.memWbFlush = 1'b0;

endmodule

//--- source/memoryStage.sv
`include "cpu_cfg.svh"

module memoryStage (
	input logic clk,
	input cpuPkg::exSlot_t exCur,
	output cpuPkg::wbSlot_t wbNext
);
	import cpuPkg::*;

	localparam int dmemAddrW = $clog2(`CPU_DMEM_WORDS);

	logic [`CPU_XLEN-1:0] dmem [`CPU_DMEM_WORDS];
	logic [dmemAddrW-1:0] wordAddr;
	logic storeEn;

	assign wordAddr = exCur.result[dmemAddrW+1:2]; // low two address bits are ignored
	assign storeEn = exCur.valid && exCur.memWrite && (exCur.excCode == excNone);

	always_ff @(posedge clk) begin
		if (storeEn) begin
			dmem[wordAddr] <= exCur.storeData;
		end
	end

	always_comb begin
		wbNext.valid = exCur.valid;
		wbNext.pc = exCur.pc;
		wbNext.rd = exCur.rd;
		wbNext.regWrite = exCur.regWrite;
		wbNext.data = exCur.memRead ? dmem[wordAddr] : exCur.result;
		wbNext.excCode = exCur.excCode;
	end

endmodule

//--- source/executeStage.sv
`include "cpu_cfg.svh"

module executeStage (
	input cpuPkg::idSlot_t idCur,
	output cpuPkg::exSlot_t exNext,
	output logic branchTaken,
	output logic [`CPU_XLEN-1:0] branchTarget
);
	import cpuPkg::*;

	localparam int msb = `CPU_XLEN - 1;

	logic [`CPU_XLEN-1:0] aluB;
	logic [`CPU_XLEN-1:0] sum;
	logic [`CPU_XLEN-1:0] result;
	logic overflow;
	logic equal;

	assign aluB = idCur.useImm ? idCur.imm : idCur.opB;
	assign sum = idCur.opA + aluB;

	always_comb begin
		case (idCur.aluOp)
			aluAdd, aluAddu: result = sum;
			aluSubu: result = idCur.opA - aluB;
			aluAnd: result = idCur.opA & aluB;
			aluOr: result = idCur.opA | aluB;
			aluXor: result = idCur.opA ^ aluB;
			aluSlt: result = {{msb{1'b0}}, $signed(idCur.opA) < $signed(aluB)};
			aluLui: result = aluB << 16;
			default: result = sum;
		endcase
	end

	// signed overflow when both operands share a sign that the sum does not
	assign overflow = idCur.valid && (idCur.aluOp == aluAdd) && (idCur.excCode == excNone)
		&& (idCur.opA[msb] == aluB[msb]) && (sum[msb] != idCur.opA[msb]);

	always_comb begin
		exNext.valid = idCur.valid;
		exNext.pc = idCur.pc;
		exNext.result = result;
		exNext.storeData = idCur.storeData;
		exNext.rd = idCur.rd;
		exNext.regWrite = idCur.regWrite && !overflow;
		exNext.memRead = idCur.memRead;
		exNext.memWrite = idCur.memWrite;
		exNext.excCode = overflow ? excOverflow : idCur.excCode;
	end

	assign equal = (idCur.opA == idCur.opB);
	assign branchTaken = idCur.valid && ((idCur.isBeq && equal) || (idCur.isBne && !equal));
	assign branchTarget = idCur.pc + 4 + (idCur.imm << 2);

endmodule

//--- source/decodeStage.sv
`include "cpu_cfg.svh"

module decodeStage (
	input logic clk,
	input cpuPkg::ifSlot_t ifCur,
	input cpuPkg::wbSlot_t wbCur,
	input cpuPkg::exSlot_t memFwd,
	input cpuPkg::fwdSel_t fwdA,
	input cpuPkg::fwdSel_t fwdB,
	output cpuPkg::idSlot_t idNext,
	output logic [4:0] rs,
	output logic [4:0] rt
);
	import cpuPkg::*;

	logic [`CPU_XLEN-1:0] regFile [32];
	logic [`CPU_XLEN-1:0] rsVal;
	logic [`CPU_XLEN-1:0] rtVal;
	opcode_t op;
	funct_t fn;
	logic legal;
	logic writes;
	logic readsRt;
	logic zeroExt;
	logic wbWe;

	function automatic logic [`CPU_XLEN-1:0] operand(input logic [4:0] idx, input fwdSel_t sel);
		logic [`CPU_XLEN-1:0] val;
		if (idx == 5'd0) begin
			val = '0;
		end else if (sel == fwdMem) begin
			val = memFwd.result;
		end else if (sel == fwdWb) begin
			val = wbCur.data; // same-cycle write is visible to the read
		end else begin
			val = regFile[idx];
		end
		return val;
	endfunction

	assign op = opcode_t'(ifCur.instr[31:26]);
	assign fn = funct_t'(ifCur.instr[5:0]);
	assign readsRt = (op == opSpecial) || (op == opSw) || (op == opBeq) || (op == opBne);
	assign rs = ifCur.instr[25:21];
	assign rt = readsRt ? ifCur.instr[20:16] : 5'd0; // rt of an immediate op is its destination
	assign wbWe = wbCur.valid && wbCur.regWrite && (wbCur.rd != 5'd0);

	always_ff @(posedge clk) begin
		if (wbWe) begin
			regFile[wbCur.rd] <= wbCur.data;
		end
	end

	always_comb begin
		rsVal = operand(rs, fwdA);
		rtVal = operand(rt, fwdB);
	end

	always_comb begin
		legal = 1'b1;
		writes = 1'b0;
		zeroExt = 1'b0;
		idNext = '0;
		idNext.aluOp = aluAddu;
		idNext.rd = ifCur.instr[20:16];
		case (op)
			opSpecial: begin
				writes = 1'b1;
				idNext.rd = ifCur.instr[15:11];
				case (fn)
					fnAdd: idNext.aluOp = aluAdd;
					fnAddu: idNext.aluOp = aluAddu;
					fnSubu: idNext.aluOp = aluSubu;
					fnAnd: idNext.aluOp = aluAnd;
					fnOr: idNext.aluOp = aluOr;
					fnXor: idNext.aluOp = aluXor;
					fnSlt: idNext.aluOp = aluSlt;
					default: legal = 1'b0;
				endcase
			end
			opAddiu: begin
				writes = 1'b1;
				idNext.useImm = 1'b1;
			end
			opOri: begin
				writes = 1'b1;
				zeroExt = 1'b1;
				idNext.useImm = 1'b1;
				idNext.aluOp = aluOr;
			end
			opLui: begin
				writes = 1'b1;
				idNext.useImm = 1'b1;
				idNext.aluOp = aluLui;
			end
			opLw: begin
				writes = 1'b1;
				idNext.useImm = 1'b1;
				idNext.memRead = 1'b1;
			end
			opSw: begin
				idNext.useImm = 1'b1;
				idNext.memWrite = 1'b1;
			end
			opBeq: idNext.isBeq = 1'b1;
			opBne: idNext.isBne = 1'b1;
			default: legal = 1'b0;
		endcase

		idNext.valid = ifCur.valid;
		idNext.pc = ifCur.pc;
		idNext.imm = zeroExt ? {{(`CPU_XLEN-16){1'b0}}, ifCur.instr[15:0]}
			: {{(`CPU_XLEN-16){ifCur.instr[15]}}, ifCur.instr[15:0]};
		idNext.opA = rsVal;
		idNext.opB = rtVal;
		idNext.storeData = rtVal;
		idNext.rs = rs;
		idNext.rt = rt;
		idNext.regWrite = ifCur.valid && legal && writes && (idNext.rd != 5'd0);
		if (!ifCur.valid || !legal) begin
			idNext.memRead = 1'b0; // a bubble or an unknown encoding has no side effect
			idNext.memWrite = 1'b0;
			idNext.isBeq = 1'b0;
			idNext.isBne = 1'b0;
		end
		idNext.excCode = (ifCur.valid && !legal) ? excReservedInstr : excNone;
	end

endmodule

//--- source/fetchStage.sv
`include "cpu_cfg.svh"

module fetchStage (
	input logic clk,
	input logic rst,
	input logic progWe,
	input logic [$clog2(`CPU_IMEM_WORDS)-1:0] progAddr,
	input logic [`CPU_XLEN-1:0] progData,
	pipeCtl.regs ctl,
	input logic branchTaken,
	input logic [`CPU_XLEN-1:0] branchTarget,
	output cpuPkg::ifSlot_t ifNext
);
	localparam int imemAddrW = $clog2(`CPU_IMEM_WORDS);

	logic [`CPU_XLEN-1:0] pc;
	logic [`CPU_XLEN-1:0] imem [`CPU_IMEM_WORDS];

	always_ff @(posedge clk) begin
		if (!rst) begin
			pc <= `CPU_RESET_PC;
		end else if (ctl.pcWr) begin
			pc <= branchTaken ? branchTarget : pc + 4; // a taken branch wins over sequential fetch
		end
	end

	// program load port, only open while the core is held in reset
	always_ff @(posedge clk) begin
		if (!rst && progWe) begin
			imem[progAddr] <= progData;
		end
	end

	always_comb begin
		ifNext.valid = 1'b1;
		ifNext.pc = pc;
		ifNext.instr = imem[pc[imemAddrW+1:2]]; // word index from the byte pc
	end

endmodule

//--- source/pipeRegs.sv
module pipeRegs (
	input logic clk,
	input logic rst,
	pipeCtl.regs ctl,
	input cpuPkg::ifSlot_t ifNext,
	input cpuPkg::idSlot_t idNext,
	input cpuPkg::exSlot_t exNext,
	input cpuPkg::wbSlot_t wbNext,
	output cpuPkg::ifSlot_t ifCur,
	output cpuPkg::idSlot_t idCur,
	output cpuPkg::exSlot_t exCur,
	output cpuPkg::wbSlot_t wbCur
);
	import cpuPkg::*;

	// a cleared slot is a bubble, its pc is left as it was
	always_ff @(posedge clk) begin
		if (!rst || ctl.ifIdFlush) begin
			ifCur.valid <= 1'b0;
		end else if (ctl.ifIdWr) begin
			ifCur <= ifNext;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst || ctl.idExFlush) begin
			idCur.valid <= 1'b0;
			idCur.regWrite <= 1'b0;
			idCur.memRead <= 1'b0;
			idCur.memWrite <= 1'b0;
			idCur.isBeq <= 1'b0;
			idCur.isBne <= 1'b0;
			idCur.excCode <= excNone;
		end else if (ctl.idExWr) begin
			idCur <= idNext;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst || ctl.exMemFlush) begin
			exCur.valid <= 1'b0;
			exCur.regWrite <= 1'b0;
			exCur.memRead <= 1'b0;
			exCur.memWrite <= 1'b0;
			exCur.excCode <= excNone;
		end else if (ctl.exMemWr) begin
			exCur <= exNext;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst || ctl.memWbFlush) begin
			wbCur.valid <= 1'b0;
			wbCur.regWrite <= 1'b0;
			wbCur.excCode <= excNone;
		end else if (ctl.memWbWr) begin
			wbCur <= wbNext;
		end
	end

endmodule

//--- source/pipeCtl.sv
interface pipeCtl;

	logic pcWr; // pc register write enable
	logic ifIdWr;
	logic idExWr;
	logic exMemWr;
	logic memWbWr;
	logic ifIdFlush;
	logic idExFlush; // also inserts the load-use bubble
	logic exMemFlush;
	logic memWbFlush;

	modport hazard (
		output pcWr, ifIdWr, idExWr, exMemWr, memWbWr,
		output ifIdFlush, idExFlush, exMemFlush, memWbFlush
	);

	modport regs (
		input pcWr, ifIdWr, idExWr, exMemWr, memWbWr,
		input ifIdFlush, idExFlush, exMemFlush, memWbFlush
	);

endinterface

//--- source/cpuPkg.sv
`include "cpu_cfg.svh"

package cpuPkg;

	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opBeq = 6'h04,
		opBne = 6'h05,
		opAddiu = 6'h09,
		opOri = 6'h0d,
		opLui = 6'h0f,
		opLw = 6'h23,
		opSw = 6'h2b
	} opcode_t;

	// function field of the SPECIAL opcode
	typedef enum logic [5:0] {
		fnAdd = 6'h20, fnAddu = 6'h21, fnSubu = 6'h23, fnAnd = 6'h24,
		fnOr = 6'h25, fnXor = 6'h26, fnSlt = 6'h2a
	} funct_t;

	typedef enum logic [3:0] {
		aluAdd, aluAddu, aluSubu, aluAnd, aluOr, aluXor, aluSlt, aluLui
	} aluOp_t;

	typedef enum logic [4:0] {
		excNone = 5'h00,
		excReservedInstr = 5'h0a,
		excOverflow = 5'h0c
	} excCode_t;

	typedef enum logic [1:0] {fwdReg, fwdMem, fwdWb} fwdSel_t;

	typedef struct packed {
		logic valid;
		logic [`CPU_XLEN-1:0] pc;
		logic [`CPU_XLEN-1:0] instr;
	} ifSlot_t;

	typedef struct packed {
		logic valid;
		logic [`CPU_XLEN-1:0] pc;
		aluOp_t aluOp;
		logic useImm;
		logic [`CPU_XLEN-1:0] imm;
		logic [`CPU_XLEN-1:0] opA, opB, storeData;
		logic [4:0] rs, rt, rd;
		logic regWrite, memRead, memWrite;
		logic isBeq, isBne;
		excCode_t excCode;
	} idSlot_t;

	typedef struct packed {
		logic valid;
		logic [`CPU_XLEN-1:0] pc;
		logic [`CPU_XLEN-1:0] result, storeData;
		logic [4:0] rd;
		logic regWrite, memRead, memWrite;
		excCode_t excCode;
	} exSlot_t;

	typedef struct packed {
		logic valid;
		logic [`CPU_XLEN-1:0] pc;
		logic [4:0] rd;
		logic regWrite;
		logic [`CPU_XLEN-1:0] data;
		excCode_t excCode;
	} wbSlot_t;

endpackage

//--- source/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// data path and address width
`define CPU_XLEN 32

// memory depths in 32-bit words
`define CPU_IMEM_WORDS 256
`define CPU_DMEM_WORDS 256

`define CPU_RESET_PC 32'h0000_0000 // first fetch address

`endif
